/* flist.f */
+incdir+tb
hw/dlx_pkg.sv
hw/dlx_alu.sv
hw/dlx_regfile.sv
hw/dlx_fetch.sv
hw/dlx_decode.sv
hw/dlx_execute.sv
hw/dlx_memory_wb.sv
hw/dlx_core.sv
tb/tb_dlx_core.sv

/* Makefile */
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal -j 0
TOP    := tb_dlx_core
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), pass if $(LOG) holds the pass line"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/tb_dlx_programs.svh */
// DLX test programs
// encoders for the three instruction formats and one loader that fills
// the ROM, seeds the RAM and lists the stores each program must make,
// in order. every program ends in a j to itself.
`ifndef TB_DLX_PROGRAMS_SVH
`define TB_DLX_PROGRAMS_SVH

function automatic logic [31:0] rtype(input alu_op_e f, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt);
    return {OPC_RTYPE, rd, rs, rt, 5'b0, f, 2'b0};
endfunction

function automatic logic [31:0] itype(input opcode_e op, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [16:0] n);
    return {op, rd, rs, n};
endfunction

function automatic logic [31:0] jtype(input logic [26:0] t);
    return {OPC_J, t};
endfunction

function automatic logic [31:0] sext17(input logic [16:0] n);
    return {{15{n[16]}}, n};
endfunction

task automatic emit(input logic [31:0] insn);
    rom[pc_w] = insn;
    pc_w++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] val);
    exp_addr[exp_n] = addr;
    exp_data[exp_n] = val;
    exp_n++;
endtask

task automatic load_program(input int t);
    logic [16:0] ia, ib, ic, ie;
    logic [31:0] v3, v4, v5, v6, v7;
    ia = 17'($urandom());
    ib = 17'($urandom());
    ic = 17'($urandom());
    ie = 17'($urandom());
    for (int i = 0; i < 64; i++) begin
        rom[i] = NOP_INSN;
    end
    for (int i = 0; i < 256; i++) begin
        ram[i] = $urandom();
    end
    pc_w      = 0;
    exp_n     = 0;
    seq_limit = '0;
    case (t)
        0: begin
            test_name = "fetch_seq";
            for (int r = 1; r <= 8; r++) begin
                emit(itype(OPC_ADDI, 5'(r), 0, 17'(r * 3)));  // independent
            end
            emit(itype(OPC_SW, 8, 0, 16));
            expect_store(16, 24);
            seq_limit = 32'd8;                   // addi run plus the sw
        end
        1: begin
            test_name = "bypass_chain";
            emit(itype(OPC_ADDI, 1, 0, ia));
            emit(itype(OPC_ADDI, 2, 0, ib));
            emit(rtype(ALU_ADD, 3, 1, 2));       // MX on rt, WX on rs
            emit(rtype(ALU_SUB, 4, 3, 1));
            emit(rtype(ALU_AND, 5, 4, 3));
            emit(rtype(ALU_OR, 6, 5, 2));
            emit(rtype(ALU_ADD, 7, 6, 6));       // both operands MX
            emit(itype(OPC_SW, 7, 0, 0));        // store data MX
            emit(itype(OPC_ADDI, 9, 0, 40));
            emit(itype(OPC_SW, 3, 9, 0));        // base from the addi just before
            emit(itype(OPC_ADDI, 8, 7, ic));
            emit(itype(OPC_SW, 8, 0, 3));
            emit(itype(OPC_SW, 6, 0, 1));
            v3 = sext17(ia) + sext17(ib);
            v4 = v3 - sext17(ia);
            v5 = v4 & v3;
            v6 = v5 | sext17(ib);
            v7 = v6 + v6;
            expect_store(0, v7);
            expect_store(40, v3);
            expect_store(3, v7 + sext17(ic));
            expect_store(1, v6);
        end
        2: begin
            test_name = "load_use";
            emit(itype(OPC_ADDI, 1, 0, 20));
            emit(itype(OPC_ADDI, 2, 0, ie));
            emit(itype(OPC_LW, 3, 1, 5));
            emit(rtype(ALU_ADD, 4, 3, 2));       // one stall, then WX
            emit(itype(OPC_SW, 4, 0, 50));
            emit(itype(OPC_LW, 5, 1, 6));
            emit(itype(OPC_SW, 5, 0, 51));       // data reaches M by WM
            emit(itype(OPC_LW, 6, 0, 7));
            emit(rtype(ALU_SUB, 7, 2, 6));       // loaded value on rt
            emit(itype(OPC_SW, 7, 0, 52));
            expect_store(50, ram[25] + sext17(ie));
            expect_store(51, ram[26]);
            expect_store(52, sext17(ie) - ram[7]);
        end
        3: begin
            test_name = "branches";
            ram[30] = 32'd3;
            ram[31] = 32'hffff_fffc;             // -4, only a signed blt gets it right
            emit(itype(OPC_ADDI, 1, 0, 5));
            emit(itype(OPC_ADDI, 2, 0, 9));
            emit(itype(OPC_BNE, 2, 1, 2));       // 9 != 5, taken to 5
            emit(itype(OPC_SW, 1, 0, 99));
            emit(itype(OPC_SW, 2, 0, 99));
            emit(itype(OPC_SW, 1, 0, 60));
            emit(itype(OPC_ADDI, 3, 0, 9));
            emit(itype(OPC_BNE, 3, 2, 1));       // equal, falls through
            emit(itype(OPC_SW, 3, 0, 61));
            emit(itype(OPC_LW, 4, 0, 30));
            emit(itype(OPC_BLT, 4, 2, 2));       // 3 < 9 off a load, taken to 13
            emit(itype(OPC_SW, 4, 0, 99));
            emit(itype(OPC_SW, 4, 0, 99));
            emit(itype(OPC_SW, 4, 0, 62));
            emit(itype(OPC_LW, 5, 0, 31));
            emit(itype(OPC_BLT, 2, 5, 2));       // 9 < -4 is false
            emit(itype(OPC_SW, 5, 0, 63));
            emit(itype(OPC_ADDI, 6, 5, 1));
            emit(itype(OPC_BLT, 5, 6, 1));       // -4 < -3, taken to 20
            emit(itype(OPC_SW, 6, 0, 99));
            emit(itype(OPC_LW, 7, 0, 30));
            emit(itype(OPC_BNE, 7, 4, 1));       // equal off a load
            emit(itype(OPC_SW, 7, 0, 64));
            expect_store(60, 5);
            expect_store(61, 9);
            expect_store(62, 3);
            expect_store(63, 32'hffff_fffc);
            expect_store(64, 3);
        end
        4: begin
            test_name = "jump_r0";
            emit(itype(OPC_ADDI, 0, 0, 77));     // r0 write is dropped
            emit(itype(OPC_SW, 0, 0, 70));
            emit(itype(OPC_ADDI, 1, 0, 11));
            emit(jtype(6));
            emit(itype(OPC_SW, 1, 0, 99));
            emit(itype(OPC_SW, 1, 0, 99));
            emit(itype(OPC_SW, 1, 0, 71));
            emit(rtype(ALU_ADD, 0, 1, 1));
            emit(itype(OPC_SW, 0, 0, 72));
            expect_store(70, 0);
            expect_store(71, 11);
            expect_store(72, 0);
        end
        default: test_name = "none";
    endcase
    emit(jtype(27'(pc_w)));                      // park on itself
endtask

`endif

/* tb/tb_dlx_core.sv */
// tb_dlx_core
// testbench for the five-stage DLX core. each program runs from reset
// against a combinational instruction ROM and data RAM. concurrent
// assertions check the reset state, the sequential fetch and every store
// against the expected store list of the running program.
`timescale 1ns/1ps
`default_nettype none

module tb_dlx_core import dlx_pkg::*; ();

    localparam int CLK_PERIOD  = 100;            // ns
    localparam int RST_CYCLES  = 16;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 400;            // watchdog budget per program

    logic            clock = 1'b0;
    logic            rst_n = 1'b0;
    logic [XLEN-1:0] address_imem;
    logic [XLEN-1:0] q_imem;
    logic [XLEN-1:0] address_dmem;
    logic [XLEN-1:0] data;
    logic            wren;
    logic [XLEN-1:0] q_dmem;

    logic [XLEN-1:0] rom [64] = '{default: NOP_INSN};
    logic [XLEN-1:0] ram [256] = '{default: '0};
    logic [XLEN-1:0] exp_addr [16];
    logic [XLEN-1:0] exp_data [16];
    logic [XLEN-1:0] prev_pc = '0;
    logic            prev_rst_n = 1'b0;
    logic [XLEN-1:0] seq_limit = '0;             // last pc of the addi run, 0 = off
    int              exp_n = 0;
    int              seen = 0;                   // stores seen this program
    int              pc_w = 0;                   // next rom slot while loading
    int              err_cnt = 0;
    int              fails = 0;
    string           test_name = "";

    `include "tb_dlx_programs.svh"

    // both memories answer in the same cycle
    assign q_imem = rom[address_imem[5:0]];
    assign q_dmem = ram[address_dmem[7:0]];

    dlx_core #(.RESET_PC('0)) u_dut (
        .clock, .rst_n, .address_imem, .q_imem,
        .address_dmem, .data, .wren, .q_dmem
    );

    initial begin
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // stores go to the checker only, no program reads a stored word back
    always @(posedge clock) begin
        prev_pc    <= address_imem;
        prev_rst_n <= rst_n;
        if (!rst_n) begin
            seen <= 0;
        end else if (wren) begin
            seen <= seen + 1;
        end
    end

    a_reset_state : assert property (
        @(negedge clock)
        (!rst_n || !prev_rst_n) |-> (address_imem == '0 && !wren)
    ) else begin
        $display("[ERROR] %s reset state: expected pc 0 wren 0, actual pc %0d wren %0b",
                 test_name, address_imem, wren);
        err_cnt++;
    end

    a_fetch_seq : assert property (
        @(negedge clock) disable iff (!rst_n)
        (seq_limit != '0 && prev_rst_n && address_imem <= seq_limit)
            |-> (address_imem == prev_pc + 32'd1)
    ) else begin
        $display("[ERROR] %s fetch: expected pc %0d, actual pc %0d",
                 test_name, prev_pc + 32'd1, address_imem);
        err_cnt++;
    end

    // program order, so a skipped slot that stores shows up as a mismatch
    a_store_match : assert property (
        @(negedge clock) disable iff (!rst_n)
        wren |-> (seen < exp_n && address_dmem == exp_addr[seen] && data == exp_data[seen])
    ) else begin
        $display("[ERROR] %s store %0d: expected mem[%0d] = %h, actual mem[%0d] = %h",
                 test_name, seen, exp_addr[seen], exp_data[seen], address_dmem, data);
        err_cnt++;
    end

    task automatic run_test(input int t);
        int err_before;
        @(posedge clock);
        rst_n <= 1'b0;
        load_program(t);
        err_before = err_cnt;
        repeat (RST_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        wait (seen == exp_n);                    // last store already checked
        if (err_cnt == err_before) begin
            $display("test %s: ok, %0d stores checked", test_name, exp_n);
        end else begin
            $display("test %s: %0d errors", test_name, err_cnt - err_before);
            fails++;
        end
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(32'hd6ca8abb);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, fails, err_cnt);
        if (fails == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the programs did not finish their stores within %0d cycles",
                 NUM_TESTS * TEST_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/dlx_core.sv */
// dlx_core
// five-stage DLX integer core: fetch, decode, execute, memory and
// writeback around an internal register file. only the instruction and
// data memory ports leave the block.
`timescale 1ns/1ps
`default_nettype none

module dlx_core import dlx_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clock,
    input  logic            rst_n,
    output logic [XLEN-1:0] address_imem,
    input  logic [XLEN-1:0] q_imem,
    output logic [XLEN-1:0] address_dmem,
    output logic [XLEN-1:0] data,
    output logic            wren,
    input  logic [XLEN-1:0] q_dmem
);

    logic [XLEN-1:0]   fd_pc, fd_ir, target;
    logic              stall, redirect;
    logic [REG_AW-1:0] ra, rb;
    logic [XLEN-1:0]   rdata_a, rdata_b;
    logic [XLEN-1:0]   dx_ir, dx_rs_val, dx_rt_val;
    logic [XLEN-1:0]   xm_ir, xm_alu_val, xm_rd_val;
    logic              xm_fwd, xm_load;
    logic [REG_AW-1:0] xm_rd;
    logic              wb_en;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;

    dlx_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clock, .rst_n, .stall, .redirect, .target, .q_imem,
        .address_imem, .fd_pc, .fd_ir
    );

    dlx_decode u_decode (
        .clock, .rst_n, .fd_pc, .fd_ir, .ra, .rb, .rdata_a, .rdata_b,
        .xm_fwd, .xm_load, .xm_rd, .xm_alu_val, .wb_en, .wb_rd, .wb_data,
        .stall, .redirect, .target, .dx_ir, .dx_rs_val, .dx_rt_val
    );

    dlx_execute u_execute (
        .clock, .rst_n, .dx_ir, .dx_rs_val, .dx_rt_val, .wb_en, .wb_rd, .wb_data,
        .xm_ir, .xm_alu_val, .xm_rd_val, .xm_fwd, .xm_load, .xm_rd
    );

    dlx_memory_wb u_memory_wb (
        .clock, .rst_n, .xm_ir, .xm_alu_val, .xm_rd_val, .q_dmem,
        .address_dmem, .data, .wren, .wb_en, .wb_rd, .wb_data
    );

    dlx_regfile #(.NUM_REGS(32), .DATA_W(XLEN)) u_regfile (
        .clock, .rst_n, .we(wb_en), .waddr(wb_rd), .raddr_a(ra), .raddr_b(rb),
        .wdata(wb_data), .rdata_a, .rdata_b
    );

endmodule

`default_nettype wire

/* hw/dlx_memory_wb.sv */
// dlx_memory_wb
// data memory access with the WM store-data bypass, the M/W register
// and the writeback select into the register file.
`timescale 1ns/1ps
`default_nettype none

module dlx_memory_wb import dlx_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [XLEN-1:0]   xm_ir,
    input  logic [XLEN-1:0]   xm_alu_val,
    input  logic [XLEN-1:0]   xm_rd_val,
    input  logic [XLEN-1:0]   q_dmem,
    output logic [XLEN-1:0]   address_dmem,
    output logic [XLEN-1:0]   data,
    output logic              wren,
    output logic              wb_en,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_data
);

    opcode_e           xm_op;
    opcode_e           mw_op;
    logic [REG_AW-1:0] xm_rd;
    logic [XLEN-1:0]   mw_ir, mw_alu_val, mw_ld_val;

    assign xm_op        = opcode_e'(xm_ir[31:27]);
    assign xm_rd        = xm_ir[26:22];
    assign address_dmem = xm_alu_val;            // rs + N
    assign wren         = (xm_op == OPC_SW);
    assign data         = (wb_en && wb_rd == xm_rd) ? wb_data : xm_rd_val; // WM bypass

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_ir      <= NOP_INSN;
            mw_alu_val <= '0;
            mw_ld_val  <= '0;
        end else begin
            mw_ir      <= xm_ir;
            mw_alu_val <= xm_alu_val;
            mw_ld_val  <= q_dmem;                // only meaningful for lw
        end
    end

    assign mw_op   = opcode_e'(mw_ir[31:27]);
    assign wb_rd   = mw_ir[26:22];
    assign wb_en   = (mw_op inside {OPC_RTYPE, OPC_ADDI, OPC_LW}) && (wb_rd != '0);
    assign wb_data = (mw_op == OPC_LW) ? mw_ld_val : mw_alu_val;

endmodule

`default_nettype wire

/* hw/dlx_execute.sv */
// dlx_execute
// MX/WX operand bypass, the main ALU and the X/M register. also forwards
// the sw data register and publishes the X/M summary that decode and
// the operand bypass use.
`timescale 1ns/1ps
`default_nettype none

module dlx_execute import dlx_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [XLEN-1:0]   dx_ir,
    input  logic [XLEN-1:0]   dx_rs_val,
    input  logic [XLEN-1:0]   dx_rt_val,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_data,
    output logic [XLEN-1:0]   xm_ir,
    output logic [XLEN-1:0]   xm_alu_val,
    output logic [XLEN-1:0]   xm_rd_val,
    output logic              xm_fwd,
    output logic              xm_load,
    output logic [REG_AW-1:0] xm_rd
);

    opcode_e           dx_op;
    opcode_e           xm_op;
    alu_op_e           alu_op;
    logic [REG_AW-1:0] dx_rd, dx_rs, dx_rt;
    logic [XLEN-1:0]   imm_n, rt_byp, st_val;
    logic [XLEN-1:0]   op_a, op_b, alu_res;
    logic              is_rtype;

    assign dx_op    = opcode_e'(dx_ir[31:27]);
    assign dx_rd    = dx_ir[26:22];
    assign dx_rs    = dx_ir[21:17];
    assign dx_rt    = dx_ir[16:12];
    assign is_rtype = (dx_op == OPC_RTYPE);
    assign imm_n    = {{(XLEN-17){dx_ir[16]}}, dx_ir[16:0]};

    // MX over WX over D/X value
    assign op_a   = fwd_pick(dx_rs, xm_fwd, xm_rd, xm_alu_val, wb_en, wb_rd, wb_data, dx_rs_val);
    assign rt_byp = fwd_pick(dx_rt, xm_fwd, xm_rd, xm_alu_val, wb_en, wb_rd, wb_data, dx_rt_val);
    assign op_b   = is_rtype ? rt_byp : imm_n;   // addi, lw, sw take N

    // sw data: catches a producer two ahead that decode read too early
    assign st_val = fwd_pick(dx_rd, xm_fwd, xm_rd, xm_alu_val, wb_en, wb_rd, wb_data, dx_rt_val);

    assign alu_op = is_rtype ? alu_op_e'(dx_ir[6:2]) : ALU_ADD; // address and addi add

    dlx_alu u_alu (
        .a         (op_a),
        .b         (op_b),
        .op        (alu_op),
        .result    (alu_res),
        .not_equal (),
        .less_than ()
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_ir      <= NOP_INSN;
            xm_alu_val <= '0;
            xm_rd_val  <= '0;
        end else begin
            xm_ir      <= dx_ir;
            xm_alu_val <= alu_res;
            xm_rd_val  <= st_val;                // store data, sw only
        end
    end

    // X/M summary
    assign xm_op   = opcode_e'(xm_ir[31:27]);
    assign xm_rd   = xm_ir[26:22];
    assign xm_fwd  = (xm_op == OPC_RTYPE || xm_op == OPC_ADDI) && (xm_rd != '0);
    assign xm_load = (xm_op == OPC_LW);          // value not ready until W

endmodule

`default_nettype wire

/* hw/dlx_decode.sv */
// dlx_decode
// register read addressing, branch resolution with MD/WD bypass into
// the comparator, load-use and branch-dependency stall detection, and
// the D/X register. a stall sends a bubble into D/X while fetch holds.
`timescale 1ns/1ps
`default_nettype none

module dlx_decode import dlx_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [XLEN-1:0]   fd_pc,
    input  logic [XLEN-1:0]   fd_ir,
    output logic [REG_AW-1:0] ra,
    output logic [REG_AW-1:0] rb,
    input  logic [XLEN-1:0]   rdata_a,
    input  logic [XLEN-1:0]   rdata_b,
    input  logic              xm_fwd,
    input  logic              xm_load,
    input  logic [REG_AW-1:0] xm_rd,
    input  logic [XLEN-1:0]   xm_alu_val,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_data,
    output logic              stall,
    output logic              redirect,
    output logic [XLEN-1:0]   target,
    output logic [XLEN-1:0]   dx_ir,
    output logic [XLEN-1:0]   dx_rs_val,
    output logic [XLEN-1:0]   dx_rt_val
);

    opcode_e           fd_op;
    opcode_e           dx_op;
    logic [REG_AW-1:0] fd_rs, fd_rt, fd_rd, dx_rd;
    logic [XLEN-1:0]   imm_n;
    logic [XLEN-1:0]   br_rs_val, br_rd_val;
    logic              is_rtype, is_branch, is_jump, uses_rs;
    logic              ne_flag, lt_flag, br_taken;
    logic              dx_writes, stall_ld, stall_br;

    assign fd_op = opcode_e'(fd_ir[31:27]);
    assign dx_op = opcode_e'(dx_ir[31:27]);
    assign fd_rd = fd_ir[26:22];
    assign fd_rs = fd_ir[21:17];
    assign fd_rt = fd_ir[16:12];
    assign dx_rd = dx_ir[26:22];
    assign imm_n = {{(XLEN-17){fd_ir[16]}}, fd_ir[16:0]};  // sign-extended N

    assign is_rtype  = (fd_op == OPC_RTYPE);
    assign is_branch = (fd_op == OPC_BNE) || (fd_op == OPC_BLT);
    assign is_jump   = (fd_op == OPC_J);
    assign uses_rs   = is_rtype || (fd_op inside {OPC_ADDI, OPC_LW, OPC_SW}); // rs read in X

    assign ra = fd_rs;
    assign rb = is_rtype ? fd_rt : fd_rd;        // rd for branches and sw data

    // comparator operands with MD over WD over regfile
    assign br_rs_val = fwd_pick(fd_rs, xm_fwd, xm_rd, xm_alu_val, wb_en, wb_rd, wb_data, rdata_a);
    assign br_rd_val = fwd_pick(fd_rd, xm_fwd, xm_rd, xm_alu_val, wb_en, wb_rd, wb_data, rdata_b);

    dlx_alu u_br_cmp (
        .a         (br_rs_val),
        .b         (br_rd_val),
        .op        (ALU_SUB),
        .result    (),                           // only the flags matter here
        .not_equal (ne_flag),
        .less_than (lt_flag)                     // rd < rs
    );

    assign br_taken = ((fd_op == OPC_BNE) && ne_flag) || ((fd_op == OPC_BLT) && lt_flag);

    // lw in X feeding anything that reads in X
    assign dx_writes = dx_op inside {OPC_RTYPE, OPC_ADDI, OPC_LW};
    assign stall_ld  = (dx_op == OPC_LW) && (dx_rd != '0)
                     && ((uses_rs && fd_rs == dx_rd) || (is_rtype && fd_rt == dx_rd));

    // branch needs its operands in D so a producer in X or a lw in M is too late
    assign stall_br = is_branch
                    && ((dx_writes && dx_rd != '0 && (fd_rs == dx_rd || fd_rd == dx_rd))
                    || (xm_load && xm_rd != '0 && (fd_rs == xm_rd || fd_rd == xm_rd)));

    assign stall    = stall_ld || stall_br;
    assign redirect = is_jump || (br_taken && !stall); // j never waits on operands
    assign target   = is_jump ? {{(XLEN-27){1'b0}}, fd_ir[26:0]} : fd_pc + imm_n;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_ir     <= NOP_INSN;
            dx_rs_val <= '0;
            dx_rt_val <= '0;
        end else begin
            dx_ir     <= stall ? NOP_INSN : fd_ir; // bubble on stall
            dx_rs_val <= rdata_a;
            dx_rt_val <= rdata_b;                // rt for r-type and rd otherwise
        end
    end

    // no hazard holds decode for more than two cycles
    a_stall_max_two : assert property (
        @(posedge clock) disable iff (!rst_n)
        (stall ##1 stall) |=> !stall
    );

endmodule

`default_nettype wire

/* hw/dlx_fetch.sv */
// dlx_fetch
// PC register and F/D register. advances by one word per cycle, loads
// the decode target on redirect and squashes the word fetched behind the
// branch. a stall holds both registers.
`timescale 1ns/1ps
`default_nettype none

module dlx_fetch import dlx_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] target,
    input  logic [XLEN-1:0] q_imem,
    output logic [XLEN-1:0] address_imem,
    output logic [XLEN-1:0] fd_pc,
    output logic [XLEN-1:0] fd_ir
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_seq;
    logic [XLEN-1:0] pc_next;

    assign pc_seq       = pc + 1'b1;                  // word addressed
    assign pc_next      = redirect ? target : pc_seq;
    assign address_imem = pc;                         // imem answers same cycle

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            fd_pc <= '0;
            fd_ir <= NOP_INSN;
        end else if (!stall) begin
            pc    <= pc_next;
            fd_pc <= pc_seq;                          // branch offsets are from PC+1
            fd_ir <= redirect ? NOP_INSN : q_imem;    // flush the wrong-path slot
        end
    end

    a_no_stall_with_redirect : assert property (
        @(posedge clock) disable iff (!rst_n)
        !(stall && redirect)
    );

endmodule

`default_nettype wire

/* hw/dlx_regfile.sv */
// dlx_regfile
// register file with two combinational read ports and one write port.
// r0 reads as zero and is never written; a read of the register being
// written this cycle sees the new value.
`timescale 1ns/1ps
`default_nettype none

module dlx_regfile #(
    parameter int NUM_REGS = 32,
    parameter int DATA_W   = 32
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              we,
    input  logic [4:0]        waddr,
    input  logic [4:0]        raddr_a,
    input  logic [4:0]        raddr_b,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata_a,
    output logic [DATA_W-1:0] rdata_b
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;                // r0 stays zero
        end
    end

    // write-through so decode sees the value retiring in writeback
    assign rdata_a = (raddr_a == '0) ? '0 : (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : (we && waddr == raddr_b) ? wdata : regs[raddr_b];

    // writeback never aims a write at r0
    a_no_r0_write : assert property (
        @(posedge clock) disable iff (!rst_n)
        we |-> (waddr != '0)
    );

endmodule

`default_nettype wire

/* hw/dlx_alu.sv */
// dlx_alu
// combinational add/sub/and/or unit. the flags compare b against a,
// so with a = rs and b = rd the branch sees rd != rs and rd < rs.
`timescale 1ns/1ps
`default_nettype none

module dlx_alu import dlx_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            not_equal,
    output logic            less_than
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            default: result = a + b;             // unused funct codes fall back to add
        endcase
    end

    assign not_equal = (a != b);
    assign less_than = ($signed(b) < $signed(a)); // signed, b < a

endmodule

`default_nettype wire

/* hw/dlx_pkg.sv */
// dlx_pkg
// shared widths, opcode and alu-op encodings, and the nop word for the
// five-stage DLX core. also holds the bypass priority pick that the
// decode and execute stages both use.
`default_nettype none

package dlx_pkg;

    localparam int XLEN   = 32;                  // data and address width
    localparam int REG_AW = 5;                   // register address width
    localparam int OPC_W  = 5;                   // opcode field width

    localparam logic [XLEN-1:0] NOP_INSN = '0;   // add r0, r0, r0

    // primary opcodes, insn[31:27]
    typedef enum logic [OPC_W-1:0] {
        OPC_RTYPE = 5'b00000,
        OPC_J     = 5'b00001,
        OPC_BNE   = 5'b00010,
        OPC_ADDI  = 5'b00101,
        OPC_BLT   = 5'b00110,
        OPC_SW    = 5'b00111,
        OPC_LW    = 5'b01000
    } opcode_e;

    // r-type function, insn[6:2]
    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011
    } alu_op_e;

    // newest producer wins: memory stage first, then writeback, else regfile
    function automatic logic [XLEN-1:0] fwd_pick(
        input logic [REG_AW-1:0] src,
        input logic              m_en,           // already excludes rd == 0
        input logic [REG_AW-1:0] m_rd,
        input logic [XLEN-1:0]   m_val,
        input logic              w_en,           // already excludes rd == 0
        input logic [REG_AW-1:0] w_rd,
        input logic [XLEN-1:0]   w_val,
        input logic [XLEN-1:0]   rf_val
    );
        if (m_en && m_rd == src) return m_val;
        if (w_en && w_rd == src) return w_val;
        return rf_val;
    endfunction

endpackage

`default_nettype wire
